/* common/mmio_defs.svh */
`ifndef MMIO_DEFS_SVH
`define MMIO_DEFS_SVH

// --------------------------------------------------------------------------
// address map
// --------------------------------------------------------------------------
`define ADDR_CYCLE          32'h8000_0010
`define ADDR_INSTR          32'h8000_0014
`define ADDR_CNT_CLEAR      32'h8000_0018
`define ADDR_FIFO_EMPTY     32'h8000_0020
`define ADDR_FIFO_DATA      32'h8000_0024
`define ADDR_SWITCHES       32'h8000_0028
`define ADDR_LEDS           32'h8000_0030
`define ADDR_TONE_EN        32'h8000_0034
`define ADDR_TONE_PERIOD    32'h8000_0038

// hdmi line command
`define ADDR_X0             32'h8001_0000
`define ADDR_X1             32'h8001_0004
`define ADDR_Y0             32'h8001_0008
`define ADDR_Y1             32'h8001_000c
`define ADDR_COLOR          32'h8001_0010
`define ADDR_FIRE           32'h8001_0014

`define FB_REGION           4'h9        // matched on addr[31:28]

// --------------------------------------------------------------------------
// field widths and reset values
// --------------------------------------------------------------------------
`define LED_W               6
`define PMOD_W              8
`define TONE_W              24
`define FB_ADDR_W           20
`define COORD_W             10
`define BTN_W               4
`define SW_W                2

`define BTN_FIFO_DEPTH      32
`define TONE_PERIOD_RESET   24'h555

`endif

/* common/mmio_pkg.sv */
package mmio_pkg;

    // store target, one per decoded write address
    typedef enum logic [3:0] {
        WR_NONE,
        WR_LEDS,
        WR_TONE_EN,
        WR_TONE_PERIOD,
        WR_FB,          // any store into region 9
        WR_X0,
        WR_X1,
        WR_Y0,
        WR_Y1,
        WR_COLOR,
        WR_FIRE,
        WR_CNT_CLEAR
    } mmio_wr_e;

    // load source, one per decoded read address
    typedef enum logic [2:0] {
        RD_NONE,
        RD_CYCLE,
        RD_INSTR,
        RD_FIFO_EMPTY,
        RD_FIFO_DATA,   // pops the button fifo
        RD_SWITCHES
    } mmio_rd_e;

endpackage

/* rtl/mmio_decode.sv */
`include "mmio_defs.svh"

module mmio_decode (
    input  logic                st,
    input  logic                ld,
    input  logic [31:0]         addr,
    output mmio_pkg::mmio_wr_e  wr_sel,
    output mmio_pkg::mmio_rd_e  rd_sel
);

    import mmio_pkg::*;

    // store side
    always_comb begin
        wr_sel = WR_NONE;
        if (st) begin
            if (addr[31:28] == `FB_REGION) begin
                wr_sel = WR_FB;     // whole region is the framebuffer
            end else begin
                case (addr)
                    `ADDR_LEDS:        wr_sel = WR_LEDS;
                    `ADDR_TONE_EN:     wr_sel = WR_TONE_EN;
                    `ADDR_TONE_PERIOD: wr_sel = WR_TONE_PERIOD;
                    `ADDR_X0:          wr_sel = WR_X0;
                    `ADDR_X1:          wr_sel = WR_X1;
                    `ADDR_Y0:          wr_sel = WR_Y0;
                    `ADDR_Y1:          wr_sel = WR_Y1;
                    `ADDR_COLOR:       wr_sel = WR_COLOR;
                    `ADDR_FIRE:        wr_sel = WR_FIRE;
                    `ADDR_CNT_CLEAR:   wr_sel = WR_CNT_CLEAR;
                    default:           wr_sel = WR_NONE;    // unmapped store
                endcase
            end
        end
    end

    // load side
    always_comb begin
        rd_sel = RD_NONE;
        if (ld) begin
            case (addr)
                `ADDR_CYCLE:      rd_sel = RD_CYCLE;
                `ADDR_INSTR:      rd_sel = RD_INSTR;
                `ADDR_FIFO_EMPTY: rd_sel = RD_FIFO_EMPTY;
                `ADDR_FIFO_DATA:  rd_sel = RD_FIFO_DATA;
                `ADDR_SWITCHES:   rd_sel = RD_SWITCHES;
                default:          rd_sel = RD_NONE;     // reads back zero
            endcase
        end
    end

endmodule

/* rtl/perf_counters.sv */
module perf_counters (
    input  logic                clk,
    input  logic                rst,
    input  logic                retire,
    input  mmio_pkg::mmio_wr_e  wr_sel,
    output logic [31:0]         cycle_count,
    output logic [31:0]         instr_count
);

    import mmio_pkg::*;

    logic clear;

    assign clear = (wr_sel == WR_CNT_CLEAR);

    // clear wins over both increments
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            cycle_count <= '0;
            instr_count <= '0;
        end else begin
            cycle_count <= cycle_count + 32'd1;
            if (retire) begin
                instr_count <= instr_count + 32'd1;
            end
        end
    end

endmodule

/* gpio/button_fifo.sv */
`include "mmio_defs.svh"

module button_fifo (
    input  logic                clk,
    input  logic                rst,
    input  logic [`BTN_W-1:0]   buttons,
    input  mmio_pkg::mmio_rd_e  rd_sel,
    output logic                fifo_empty,
    output logic [`BTN_W-1:0]   fifo_head
);

    import mmio_pkg::*;

    localparam int PTR_W = $clog2(`BTN_FIFO_DEPTH);
    localparam int CNT_W = $clog2(`BTN_FIFO_DEPTH + 1);

    logic [`BTN_W-1:0] mem [`BTN_FIFO_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              full;
    logic              push;
    logic              pop;

    assign fifo_empty = (count == '0);
    assign full       = (count == CNT_W'(`BTN_FIFO_DEPTH));
    assign push       = (|buttons) && !full;        // idle level is all zero
    assign pop        = (rd_sel == RD_FIFO_DATA) && !fifo_empty;
    assign fifo_head  = fifo_empty ? '0 : mem[rd_ptr];

    // storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= buttons;
        end
    end

    // pointers and occupancy
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(`BTN_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(`BTN_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // both or neither
            endcase
        end
    end

endmodule

/* rtl/mmio_regs.sv */
`include "mmio_defs.svh"

module mmio_regs (
    input  logic                    clk,
    input  logic                    rst,
    input  mmio_pkg::mmio_wr_e      wr_sel,
    input  logic [31:0]             addr,
    input  logic [31:0]             wdata,
    input  logic                    hdmi_ready,
    output logic [`LED_W-1:0]       leds,
    output logic [`PMOD_W-1:0]      pmod_leds,
    output logic                    tone_enable,
    output logic [`TONE_W-1:0]      tone_period,
    output logic                    fb_we,
    output logic [`FB_ADDR_W-1:0]   fb_addr,
    output logic                    fb_data,
    output logic [`COORD_W-1:0]     x0,
    output logic [`COORD_W-1:0]     x1,
    output logic [`COORD_W-1:0]     y0,
    output logic [`COORD_W-1:0]     y1,
    output logic                    color,
    output logic                    hdmi_valid
);

    import mmio_pkg::*;

    // ------------------------------------------------------------------------
    // board leds and tone generator
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            leds        <= '0;
            pmod_leds   <= '0;
            tone_enable <= 1'b0;
            tone_period <= `TONE_PERIOD_RESET;
        end else begin
            case (wr_sel)
                WR_LEDS: begin
                    leds      <= wdata[`LED_W-1:0];
                    pmod_leds <= wdata[8 +: `PMOD_W];   // second byte
                end
                WR_TONE_EN:     tone_enable <= wdata[0];
                WR_TONE_PERIOD: tone_period <= wdata[`TONE_W-1:0];
                default: ;
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // framebuffer write pulse
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst || wr_sel != WR_FB) begin
            fb_we   <= 1'b0;
            fb_addr <= '0;      // idle bus reads as zero
            fb_data <= 1'b0;
        end else begin
            fb_we   <= 1'b1;
            fb_addr <= addr[`FB_ADDR_W-1:0];
            fb_data <= wdata[0];
        end
    end

    // ------------------------------------------------------------------------
    // hdmi line command
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            x0         <= '0;
            x1         <= '0;
            y0         <= '0;
            y1         <= '0;
            color      <= 1'b0;
            hdmi_valid <= 1'b0;
        end else begin
            hdmi_valid <= (wr_sel == WR_FIRE) && hdmi_ready;  // fire dropped if not ready
            case (wr_sel)
                WR_X0:    x0    <= wdata[`COORD_W-1:0];
                WR_X1:    x1    <= wdata[`COORD_W-1:0];
                WR_Y0:    y0    <= wdata[`COORD_W-1:0];
                WR_Y1:    y1    <= wdata[`COORD_W-1:0];
                WR_COLOR: color <= wdata[0];
                default: ;
            endcase
        end
    end

endmodule

/* rtl/mmio_read_mux.sv */
`include "mmio_defs.svh"

module mmio_read_mux (
    input  logic                clk,
    input  logic                rst,
    input  mmio_pkg::mmio_rd_e  rd_sel,
    input  logic [31:0]         cycle_count,
    input  logic [31:0]         instr_count,
    input  logic                fifo_empty,
    input  logic [`BTN_W-1:0]   fifo_head,
    input  logic [`SW_W-1:0]    switches,
    output logic [31:0]         rdata
);

    import mmio_pkg::*;

    // writeback stage register, one cycle after the load edge
    always_ff @(posedge clk) begin
        if (rst) begin
            rdata <= '0;
        end else begin
            case (rd_sel)
                RD_CYCLE:      rdata <= cycle_count;
                RD_INSTR:      rdata <= instr_count;
                RD_FIFO_EMPTY: rdata <= {31'b0, fifo_empty};
                RD_FIFO_DATA:  rdata <= {{(32 - `BTN_W){1'b0}}, fifo_head};  // zero when empty
                RD_SWITCHES:   rdata <= {{(32 - `SW_W){1'b0}}, switches};
                default:       rdata <= '0;
            endcase
        end
    end

endmodule

/* rtl/mmio_top.sv */
`include "mmio_defs.svh"

module mmio_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    st,
    input  logic                    ld,
    input  logic [31:0]             addr,
    input  logic [31:0]             wdata,
    input  logic                    retire,
    input  logic [`BTN_W-1:0]       buttons,
    input  logic [`SW_W-1:0]        switches,
    input  logic                    hdmi_ready,
    output logic [`LED_W-1:0]       leds,
    output logic [`PMOD_W-1:0]      pmod_leds,
    output logic                    tone_enable,
    output logic [`TONE_W-1:0]      tone_period,
    output logic                    fb_we,
    output logic [`FB_ADDR_W-1:0]   fb_addr,
    output logic                    fb_data,
    output logic [`COORD_W-1:0]     x0,
    output logic [`COORD_W-1:0]     x1,
    output logic [`COORD_W-1:0]     y0,
    output logic [`COORD_W-1:0]     y1,
    output logic                    color,
    output logic                    hdmi_valid,
    output logic [31:0]             rdata
);

    import mmio_pkg::*;

    mmio_wr_e           wr_sel;
    mmio_rd_e           rd_sel;
    logic [31:0]        cycle_count;
    logic [31:0]        instr_count;
    logic               fifo_empty;
    logic [`BTN_W-1:0]  fifo_head;

    mmio_decode u_decode (
        .st     (st),
        .ld     (ld),
        .addr   (addr),
        .wr_sel (wr_sel),
        .rd_sel (rd_sel)
    );

    perf_counters u_counters (
        .clk         (clk),
        .rst         (rst),
        .retire      (retire),
        .wr_sel      (wr_sel),
        .cycle_count (cycle_count),
        .instr_count (instr_count)
    );

    button_fifo u_btn_fifo (
        .clk        (clk),
        .rst        (rst),
        .buttons    (buttons),
        .rd_sel     (rd_sel),
        .fifo_empty (fifo_empty),
        .fifo_head  (fifo_head)
    );

    mmio_regs u_regs (
        .clk         (clk),
        .rst         (rst),
        .wr_sel      (wr_sel),
        .addr        (addr),
        .wdata       (wdata),
        .hdmi_ready  (hdmi_ready),
        .leds        (leds),
        .pmod_leds   (pmod_leds),
        .tone_enable (tone_enable),
        .tone_period (tone_period),
        .fb_we       (fb_we),
        .fb_addr     (fb_addr),
        .fb_data     (fb_data),
        .x0          (x0),
        .x1          (x1),
        .y0          (y0),
        .y1          (y1),
        .color       (color),
        .hdmi_valid  (hdmi_valid)
    );

    mmio_read_mux u_read_mux (
        .clk         (clk),
        .rst         (rst),
        .rd_sel      (rd_sel),
        .cycle_count (cycle_count),
        .instr_count (instr_count),
        .fifo_empty  (fifo_empty),
        .fifo_head   (fifo_head),
        .switches    (switches),
        .rdata       (rdata)
    );

endmodule

/* test/mmio_checker.sv */
`include "mmio_defs.svh"

module mmio_checker (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    st,
    input  logic                    ld,
    input  logic [31:0]             addr,
    input  logic [31:0]             wdata,
    input  logic                    retire,
    input  logic [`BTN_W-1:0]       buttons,
    input  logic [`SW_W-1:0]        switches,
    input  logic                    hdmi_ready,
    input  logic [`LED_W-1:0]       leds,
    input  logic [`PMOD_W-1:0]      pmod_leds,
    input  logic                    tone_enable,
    input  logic [`TONE_W-1:0]      tone_period,
    input  logic                    fb_we,
    input  logic [`FB_ADDR_W-1:0]   fb_addr,
    input  logic                    fb_data,
    input  logic [`COORD_W-1:0]     x0,
    input  logic [`COORD_W-1:0]     x1,
    input  logic [`COORD_W-1:0]     y0,
    input  logic [`COORD_W-1:0]     y1,
    input  logic                    color,
    input  logic                    hdmi_valid,
    input  logic [31:0]             rdata
);

    string test_name = "reset";
    int    test_checks = 0;
    int    test_errors = 0;
    int    total_errors = 0;
    int    tests_run = 0;
    int    tests_passed = 0;
    logic  model_valid = 1'b0;      // set once a reset edge was seen

    logic [`LED_W-1:0]      m_leds;
    logic [`PMOD_W-1:0]     m_pmod;
    logic                   m_tone_en;
    logic [`TONE_W-1:0]     m_tone_period;
    logic                   m_fb_we;
    logic [`FB_ADDR_W-1:0]  m_fb_addr;
    logic                   m_fb_data;
    logic [`COORD_W-1:0]    m_x0;
    logic [`COORD_W-1:0]    m_x1;
    logic [`COORD_W-1:0]    m_y0;
    logic [`COORD_W-1:0]    m_y1;
    logic                   m_color;
    logic                   m_hdmi_valid;
    logic [31:0]            m_rdata;
    logic [31:0]            m_cycle;
    logic [31:0]            m_instr;
    logic [`BTN_W-1:0]      m_fifo [$];

    // ------------------------------------------------------------------------
    // test bookkeeping driven from the testbench top
    // ------------------------------------------------------------------------
    task automatic start_test(input string name);
        test_name   = name;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests_run++;
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %s: ok, %0d checks", test_name, test_checks);
        end else begin
            $display("test %s: FAILED, %0d of %0d checks wrong",
                     test_name, test_errors, test_checks);
        end
    endtask

    task automatic report();
        $display("tests run %0d, passed %0d, failed %0d, total errors %0d",
                 tests_run, tests_passed, tests_run - tests_passed, total_errors);
    endtask

    task automatic check_value(input string sig, input logic [31:0] expected,
                               input logic [31:0] actual);
        test_checks++;
        if (actual !== expected) begin
            test_errors++;
            total_errors++;
            $display("ERROR test %s, %s: expected %0h, actual %0h",
                     test_name, sig, expected, actual);
        end
    endtask

    // ------------------------------------------------------------------------
    // reference model stepped at each rising edge
    // ------------------------------------------------------------------------
    always @(posedge clk) begin : model_step
        logic in_fb;
        logic do_push;
        in_fb   = (addr[31:28] == `FB_REGION);
        do_push = (buttons != '0) && (m_fifo.size() < `BTN_FIFO_DEPTH);
        if (rst) begin
            model_valid   = 1'b1;
            m_leds        = '0;
            m_pmod        = '0;
            m_tone_en     = 1'b0;
            m_tone_period = 24'h555;
            m_fb_we       = 1'b0;
            m_fb_addr     = '0;
            m_fb_data     = 1'b0;
            {m_x0, m_x1, m_y0, m_y1, m_color} = '0;
            m_hdmi_valid  = 1'b0;
            m_rdata       = '0;
            m_cycle       = '0;
            m_instr       = '0;
            m_fifo.delete();
        end else begin
            // load value comes from state before this edge
            m_rdata = '0;
            if (ld) begin
                case (addr)
                    `ADDR_CYCLE:      m_rdata = m_cycle;
                    `ADDR_INSTR:      m_rdata = m_instr;
                    `ADDR_FIFO_EMPTY: m_rdata = (m_fifo.size() == 0) ? 32'd1 : 32'd0;
                    `ADDR_FIFO_DATA:  m_rdata = (m_fifo.size() == 0) ? 32'd0 : 32'(m_fifo[0]);
                    `ADDR_SWITCHES:   m_rdata = 32'(switches);
                    default:          m_rdata = '0;
                endcase
                if (addr == `ADDR_FIFO_DATA && m_fifo.size() != 0) begin
                    void'(m_fifo.pop_front());
                end
            end
            if (do_push) begin
                m_fifo.push_back(buttons);
            end
            if (st && !in_fb && addr == `ADDR_CNT_CLEAR) begin
                m_cycle = '0;
                m_instr = '0;
            end else begin
                m_cycle = m_cycle + 32'd1;
                m_instr = m_instr + (retire ? 32'd1 : 32'd0);
            end
            m_fb_we      = st && in_fb;
            m_fb_addr    = m_fb_we ? addr[`FB_ADDR_W-1:0] : '0;
            m_fb_data    = m_fb_we ? wdata[0] : 1'b0;
            m_hdmi_valid = st && !in_fb && (addr == `ADDR_FIRE) && hdmi_ready;
            if (st && !in_fb) begin
                case (addr)
                    `ADDR_LEDS: begin
                        m_leds = wdata[5:0];
                        m_pmod = wdata[15:8];
                    end
                    `ADDR_TONE_EN:     m_tone_en = wdata[0];
                    `ADDR_TONE_PERIOD: m_tone_period = wdata[23:0];
                    `ADDR_X0:          m_x0 = wdata[9:0];
                    `ADDR_X1:          m_x1 = wdata[9:0];
                    `ADDR_Y0:          m_y0 = wdata[9:0];
                    `ADDR_Y1:          m_y1 = wdata[9:0];
                    `ADDR_COLOR:       m_color = wdata[0];
                    default: ;
                endcase
            end
        end
    end

    // compare mid-cycle against the model
    always @(negedge clk) begin
        if (model_valid) begin
            check_value("leds", 32'(m_leds), 32'(leds));
            check_value("pmod_leds", 32'(m_pmod), 32'(pmod_leds));
            check_value("tone_enable", 32'(m_tone_en), 32'(tone_enable));
            check_value("tone_period", 32'(m_tone_period), 32'(tone_period));
            check_value("fb_we", 32'(m_fb_we), 32'(fb_we));
            check_value("fb_addr", 32'(m_fb_addr), 32'(fb_addr));
            check_value("fb_data", 32'(m_fb_data), 32'(fb_data));
            check_value("x0", 32'(m_x0), 32'(x0));
            check_value("x1", 32'(m_x1), 32'(x1));
            check_value("y0", 32'(m_y0), 32'(y0));
            check_value("y1", 32'(m_y1), 32'(y1));
            check_value("color", 32'(m_color), 32'(color));
            check_value("hdmi_valid", 32'(m_hdmi_valid), 32'(hdmi_valid));
            check_value("rdata", m_rdata, rdata);
        end
    end

endmodule

/* test/tb_mmio.sv */
`include "mmio_defs.svh"

module tb_mmio;

    localparam int RESET_CYCLES = 5;
    localparam int CNT_LEN      = 150;
    localparam int REG_LEN      = 120;
    localparam int FB_LEN       = 120;
    localparam int HDMI_LEN     = 120;
    localparam int BTN_LEN      = 240;
    localparam int FILL_LEN     = 64;     // long enough to overflow the fifo
    localparam int TOTAL_CYCLES = RESET_CYCLES + CNT_LEN + REG_LEN + FB_LEN
                                  + HDMI_LEN + BTN_LEN + 5 * 3;
    localparam int TIMEOUT      = (TOTAL_CYCLES + 200) * 20;

    logic                   clk = 1'b0;
    logic                   rst;
    logic                   st;
    logic                   ld;
    logic [31:0]            addr;
    logic [31:0]            wdata;
    logic                   retire;
    logic [`BTN_W-1:0]      buttons;
    logic [`SW_W-1:0]       switches;
    logic                   hdmi_ready;
    logic [`LED_W-1:0]      leds;
    logic [`PMOD_W-1:0]     pmod_leds;
    logic                   tone_enable;
    logic [`TONE_W-1:0]     tone_period;
    logic                   fb_we;
    logic [`FB_ADDR_W-1:0]  fb_addr;
    logic                   fb_data;
    logic [`COORD_W-1:0]    x0;
    logic [`COORD_W-1:0]    x1;
    logic [`COORD_W-1:0]    y0;
    logic [`COORD_W-1:0]    y1;
    logic                   color;
    logic                   hdmi_valid;
    logic [31:0]            rdata;
    logic [31:0]            rng_state;

    always #10 clk = ~clk;

    mmio_top UUT (.*);

    mmio_checker u_checker (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic drive_idle();
        st      = 1'b0;
        ld      = 1'b0;
        addr    = '0;
        wdata   = '0;
        retire  = 1'b0;
        buttons = '0;
    endtask

    // falling edge, idle bus, fresh random word
    task automatic next_cycle(output logic [31:0] r);
        @(negedge clk);
        drive_idle();
        rng_state = xorshift(rng_state);
        r = rng_state;
    endtask

    task automatic run_test(input string name, input int id, input int len);
        logic [31:0] r;
        logic [31:0] r2;
        logic        after_clear;
        after_clear = 1'b0;
        u_checker.start_test(name);
        for (int i = 0; i < len; i++) begin
            next_cycle(r);
            r2 = xorshift(r ^ 32'h5a5a_1234);
            case (id)
                0: begin                        // counters and clear
                    retire = r[0];
                    if (after_clear) begin
                        ld          = 1'b1;
                        addr        = r[1] ? `ADDR_CYCLE : `ADDR_INSTR;
                        after_clear = 1'b0;
                    end else if (r[7:4] == 4'h0) begin
                        st          = 1'b1;
                        addr        = `ADDR_CNT_CLEAR;
                        wdata       = r2;
                        after_clear = 1'b1;
                    end else if (r[3:2] != 2'b00) begin
                        ld   = 1'b1;
                        addr = r[8] ? `ADDR_CYCLE : `ADDR_INSTR;
                    end
                end
                1: begin                        // leds and tone
                    st    = (r[1:0] != 2'b00);
                    wdata = r2;
                    case (r[3:2])
                        2'd0:    addr = `ADDR_LEDS;
                        2'd1:    addr = `ADDR_TONE_EN;
                        2'd2:    addr = `ADDR_TONE_PERIOD;
                        default: addr = 32'h8000_003c;  // unmapped
                    endcase
                end
                2: begin                        // framebuffer in and out of region
                    st    = r[0];
                    wdata = r2;
                    addr  = {r[1] ? `FB_REGION : ((r[7:4] == `FB_REGION) ? 4'h1 : r[7:4]),
                             r2[27:0]};
                end
                3: begin                        // hdmi line command
                    hdmi_ready = r[0];
                    st         = (r[2:1] != 2'b00);
                    wdata      = r2;
                    addr       = (r[5:3] > 3'd5) ? `ADDR_FIRE : `ADDR_X0 + {27'b0, r[5:3], 2'b00};
                end
                default: begin                  // button fifo and switches
                    switches = r[1:0];
                    if (i < FILL_LEN) begin
                        buttons = r[15:12] | 4'h1;
                        ld      = (r[21:19] == 3'b000);
                    end else begin
                        buttons = (r[10:8] == 3'b000) ? r[15:12] : 4'h0;
                        ld      = (r[17:16] != 2'b00);
                    end
                    case (r[19:18])
                        2'd0:    addr = `ADDR_FIFO_EMPTY;
                        2'd3:    addr = `ADDR_SWITCHES;
                        default: addr = `ADDR_FIFO_DATA;
                    endcase
                end
            endcase
        end
        @(negedge clk);
        drive_idle();
        @(posedge clk);
        #1;
        u_checker.end_test();
    endtask

    initial begin
        rst        = 1'b1;
        switches   = '0;
        hdmi_ready = 1'b0;
        rng_state  = 32'd10501;
        drive_idle();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(posedge clk);
        #1;
        run_test("counters", 0, CNT_LEN);
        run_test("leds_tone", 1, REG_LEN);
        run_test("framebuffer", 2, FB_LEN);
        run_test("hdmi", 3, HDMI_LEN);
        run_test("buttons_switches", 4, BTN_LEN);
        u_checker.report();
        if (u_checker.total_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(TIMEOUT);
        $display("watchdog: run did not finish within %0d time units", TIMEOUT);
        $display("Simulation failed");
        $finish;
    end

endmodule

/* build.f */
+incdir+common
common/mmio_pkg.sv
rtl/mmio_decode.sv
rtl/perf_counters.sv
gpio/button_fifo.sv
rtl/mmio_regs.sv
rtl/mmio_read_mux.sv
rtl/mmio_top.sv
test/mmio_checker.sv
test/tb_mmio.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run tb_mmio, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -f build.f --top-module tb_mmio -Mdir obj_dir
	./obj_dir/Vtb_mmio | tee sim.log
	grep -q "^Simulation passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
